// File: smem_config.svh
`ifndef SMEM_CONFIG_SVH
`define SMEM_CONFIG_SVH

// ------------------------------------------------------------
// batch geometry
// ------------------------------------------------------------

// reads per batch and width of a read number
`define SMEM_MAX_READ 16
`define SMEM_READ_NUM_WIDTH 4

// banking, top read number bits pick the bank
`define SMEM_BANKS 4
`define SMEM_BANK_SEL_WIDTH 2

// mem slots per read, local bank address covers 4 reads of 20 slots
`define SMEM_SLOTS 20
`define SMEM_BANK_ADDR_WIDTH 7

// mem count, return code and slot index
`define SMEM_SIZE_WIDTH 7

// one output beat
`define SMEM_OUT_WIDTH 512

`endif

// File: smem_pkg.sv
`include "smem_config.svh"

package smem_pkg;

	// ------------------------------------------------------------
	// datapath side
	// ------------------------------------------------------------

	// one seed match, 113 bits
	typedef struct packed {
		logic [6:0]  info_hi;
		logic [6:0]  info_lo;
		logic [32:0] x2;
		logic [32:0] x1;
		logic [32:0] x0;
	} mem_entry_t;

	// mem write from the datapath
	typedef struct packed {
		logic                            we;
		logic [`SMEM_READ_NUM_WIDTH-1:0] read_num;
		logic [`SMEM_SIZE_WIDTH-1:0]     slot;
		mem_entry_t                      entry;
	} mem_write_t;

	// per-read mem count and return code
	typedef struct packed {
		logic                            valid;
		logic [`SMEM_READ_NUM_WIDTH-1:0] read_num;
		logic [`SMEM_SIZE_WIDTH-1:0]     size;
		logic [`SMEM_SIZE_WIDTH-1:0]     ret;
	} size_report_t;

	// ------------------------------------------------------------
	// output side
	// ------------------------------------------------------------

	// streamer read request, local bank addresses
	typedef struct packed {
		logic [`SMEM_BANK_ADDR_WIDTH-1:0] addr_a;
		logic [`SMEM_BANK_ADDR_WIDTH-1:0] addr_b;
	} bank_rd_t;

	typedef enum logic [2:0] {
		HEADER,
		PAIRS,
		TAIL,
		GAP,
		FINISHED
	} stream_state_t;

endpackage

// File: smem_bank.sv
`timescale 1ns/1ps
`include "smem_config.svh"

module smem_bank (
	input  logic                             clk,
	input  logic                             enable,
	input  logic                             we,
	input  logic [`SMEM_BANK_ADDR_WIDTH-1:0] addr_a,
	input  smem_pkg::mem_entry_t             wdata,
	input  logic [`SMEM_BANK_ADDR_WIDTH-1:0] addr_b,
	output smem_pkg::mem_entry_t             q_a,
	output smem_pkg::mem_entry_t             q_b
);

	// four reads of SMEM_SLOTS entries each
	localparam int DEPTH = `SMEM_MAX_READ / `SMEM_BANKS * `SMEM_SLOTS;

	smem_pkg::mem_entry_t mem [DEPTH];

	// enable doubles as the stall freeze
	always_ff @(posedge clk) begin
		if (enable) begin
			if (we) begin
				mem[addr_a] <= wdata;
			end
			// read-first on port A
			q_a <= mem[addr_a];
		end
	end

	// port B only reads
	always_ff @(posedge clk) begin
		if (enable) begin
			q_b <= mem[addr_b];
		end
	end

endmodule

// File: smem_write_router.sv
`timescale 1ns/1ps
`include "smem_config.svh"

module smem_write_router (
	input  logic                             clk,
	input  logic                             reset_n,
	input  logic                             stall,
	input  smem_pkg::mem_write_t             mem_wr,
	input  smem_pkg::bank_rd_t               rd,
	output logic [`SMEM_BANKS-1:0]           bank_we,
	output logic [`SMEM_BANK_ADDR_WIDTH-1:0] addr_a,
	output smem_pkg::mem_entry_t             wdata,
	output logic [`SMEM_BANK_ADDR_WIDTH-1:0] addr_b
);

	// read number bits that index inside a bank
	localparam int LOW_W = `SMEM_READ_NUM_WIDTH - `SMEM_BANK_SEL_WIDTH;

	logic [`SMEM_BANK_ADDR_WIDTH-1:0] wr_addr;
	logic [`SMEM_BANK_ADDR_WIDTH-1:0] addr_mux;

	logic                             we_q;
	logic [`SMEM_BANK_SEL_WIDTH-1:0]  bank_q;
	logic [`SMEM_BANK_ADDR_WIDTH-1:0] addr_a_q;
	logic [`SMEM_BANK_ADDR_WIDTH-1:0] addr_b_q;
	smem_pkg::mem_entry_t             entry_q;

	assign wr_addr = `SMEM_BANK_ADDR_WIDTH'(mem_wr.read_num[LOW_W-1:0] * `SMEM_SLOTS + mem_wr.slot);

	// a write takes port A over the streamer
	assign addr_mux = mem_wr.we ? wr_addr : rd.addr_a;

	// ------------------------------------------------------------
	// stage one
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			we_q <= 1'b0;
		end else if (!stall) begin
			we_q <= mem_wr.we;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			bank_q   <= mem_wr.read_num[`SMEM_READ_NUM_WIDTH-1 -: `SMEM_BANK_SEL_WIDTH];
			addr_a_q <= addr_mux;
			addr_b_q <= rd.addr_b;
			entry_q  <= mem_wr.entry;
		end
	end

	// ------------------------------------------------------------
	// stage two, bank decode
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			bank_we <= '0;
		end else if (!stall) begin
			bank_we <= we_q ? (`SMEM_BANKS'(1) << bank_q) : '0;
		end
	end

	// shared by all banks, only the enable is per bank
	always_ff @(posedge clk) begin
		if (!stall) begin
			addr_a <= addr_a_q;
			addr_b <= addr_b_q;
			wdata  <= entry_q;
		end
	end

	// slot past the end would land in the next read's region
	slot_in_range: assert property (@(posedge clk) disable iff (!reset_n)
		mem_wr.we |-> mem_wr.slot < `SMEM_SLOTS);

endmodule

// File: smem_batch_tracker.sv
`timescale 1ns/1ps
`include "smem_config.svh"

module smem_batch_tracker (
	input  logic                            clk,
	input  logic                            reset_n,
	input  logic                            stall,
	input  smem_pkg::size_report_t          size_rep,
	input  logic [`SMEM_READ_NUM_WIDTH:0]   batch_size,
	input  logic [`SMEM_READ_NUM_WIDTH-1:0] rd_num,
	output logic [`SMEM_SIZE_WIDTH-1:0]     rd_size,
	output logic [`SMEM_SIZE_WIDTH-1:0]     rd_ret,
	output logic [`SMEM_READ_NUM_WIDTH:0]   done_counter,
	output logic                            output_request
);

	smem_pkg::size_report_t      rep_q;
	logic                        all_read_done;
	logic [`SMEM_SIZE_WIDTH-1:0] size_tab [`SMEM_MAX_READ];
	logic [`SMEM_SIZE_WIDTH-1:0] ret_tab  [`SMEM_MAX_READ];

	// report register
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			rep_q <= '0;
		end else if (!stall) begin
			rep_q <= size_rep;
		end
	end

	// ------------------------------------------------------------
	// per-read tables
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!stall && rep_q.valid) begin
			size_tab[rep_q.read_num] <= rep_q.size;
			ret_tab[rep_q.read_num]  <= rep_q.ret;
		end
	end

	// streamer lookup
	assign rd_size = size_tab[rd_num];
	assign rd_ret  = ret_tab[rd_num];

	// ------------------------------------------------------------
	// done count and request
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			done_counter   <= '0;
			all_read_done  <= 1'b0;
			output_request <= 1'b0;
		end else if (!stall) begin
			if (rep_q.valid) begin
				done_counter <= done_counter + 1'b1;
			end
			// empty batch never asks for output
			all_read_done  <= (done_counter == batch_size) && (batch_size != '0);
			output_request <= all_read_done;
		end
	end

	size_in_range: assert property (@(posedge clk) disable iff (!reset_n)
		size_rep.valid |-> size_rep.size <= `SMEM_SLOTS);

endmodule

// File: smem_output_streamer.sv
`timescale 1ns/1ps
`include "smem_config.svh"

module smem_output_streamer (
	input  logic                            clk,
	input  logic                            reset_n,
	input  logic                            stall,
	input  logic                            output_permit,
	input  logic [`SMEM_READ_NUM_WIDTH:0]   batch_size,
	input  logic [`SMEM_SIZE_WIDTH-1:0]     rd_size,
	input  logic [`SMEM_SIZE_WIDTH-1:0]     rd_ret,
	output logic [`SMEM_READ_NUM_WIDTH-1:0] rd_num,
	output smem_pkg::bank_rd_t              rd,
	input  smem_pkg::mem_entry_t            q_a [`SMEM_BANKS],
	input  smem_pkg::mem_entry_t            q_b [`SMEM_BANKS],
	output logic [`SMEM_OUT_WIDTH-1:0]      output_data,
	output logic                            output_valid,
	output logic                            output_finish
);

	localparam int LOW_W  = `SMEM_READ_NUM_WIDTH - `SMEM_BANK_SEL_WIDTH;
	localparam int HALF_W = `SMEM_OUT_WIDTH / 2;
	// router 2 + bank 1 cycles, then bank select
	localparam int DEPTH  = 4;

	// what one state step hands down the pipe
	typedef struct packed {
		logic                            valid;
		logic                            finish;
		smem_pkg::stream_state_t         state;
		logic [`SMEM_READ_NUM_WIDTH-1:0] read_num;
		logic [`SMEM_SIZE_WIDTH-1:0]     size;
		logic [`SMEM_SIZE_WIDTH-1:0]     ret;
	} step_t;

	smem_pkg::stream_state_t          state;
	smem_pkg::stream_state_t          state_next;
	logic [`SMEM_READ_NUM_WIDTH-1:0]  read_ptr;
	logic [`SMEM_SIZE_WIDTH-1:0]      slot;
	logic [`SMEM_SIZE_WIDTH-1:0]      slot_next;
	logic [`SMEM_BANK_ADDR_WIDTH-1:0] base_addr;
	logic                             last_read;
	step_t                            step_cur;
	step_t                            pipe [1:DEPTH];
	smem_pkg::mem_entry_t             sel_a;
	smem_pkg::mem_entry_t             sel_b;
	logic [`SMEM_OUT_WIDTH-1:0]       word;

	// entry layout inside a 256-bit half
	function automatic logic [HALF_W-1:0] pack_half(smem_pkg::mem_entry_t e);
		logic [HALF_W-1:0] h;
		h = '0;
		h[230:224] = e.info_hi;
		h[198:192] = e.info_lo;
		h[160:128] = e.x2;
		h[96:64]   = e.x1;
		h[32:0]    = e.x0;
		return h;
	endfunction

	// ------------------------------------------------------------
	// read walk FSM
	// ------------------------------------------------------------

	assign rd_num    = read_ptr;
	assign base_addr = `SMEM_BANK_ADDR_WIDTH'(read_ptr[LOW_W-1:0] * `SMEM_SLOTS);
	assign last_read = ({1'b0, read_ptr} + 1'b1) == batch_size;

	always_comb begin
		state_next = state;
		slot_next  = slot;
		rd.addr_a  = base_addr + slot;
		rd.addr_b  = base_addr + slot;
		case (state)
			smem_pkg::HEADER: begin
				slot_next = '0;
				if (rd_size == '0) begin
					state_next = smem_pkg::GAP;
				end else if (rd_size == `SMEM_SIZE_WIDTH'(1)) begin
					state_next = smem_pkg::TAIL;
				end else begin
					state_next = smem_pkg::PAIRS;
				end
			end
			smem_pkg::PAIRS: begin
				rd.addr_b = base_addr + slot + 1'b1;
				slot_next = slot + 2'd2;
				if (slot_next == rd_size) begin
					state_next = smem_pkg::GAP;
				end else if (slot_next + 1'b1 == rd_size) begin
					state_next = smem_pkg::TAIL;
				end else begin
					state_next = smem_pkg::PAIRS;
				end
			end
			smem_pkg::TAIL: begin
				state_next = smem_pkg::GAP;
			end
			smem_pkg::GAP: begin
				state_next = last_read ? smem_pkg::FINISHED : smem_pkg::HEADER;
			end
			default: begin
				state_next = state;
			end
		endcase
	end

	// holds in place without permit
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state    <= smem_pkg::HEADER;
			read_ptr <= '0;
			slot     <= '0;
		end else if (!stall && output_permit) begin
			state <= state_next;
			slot  <= slot_next;
			if (state == smem_pkg::GAP) begin
				read_ptr <= read_ptr + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------
	// step pipeline
	// ------------------------------------------------------------

	// no permit means a bubble
	always_comb begin
		step_cur.valid    = output_permit && (state == smem_pkg::HEADER ||
			state == smem_pkg::PAIRS || state == smem_pkg::TAIL);
		step_cur.finish   = state == smem_pkg::FINISHED;
		step_cur.state    = state;
		step_cur.read_num = read_ptr;
		step_cur.size     = rd_size;
		step_cur.ret      = rd_ret;
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 1; i <= DEPTH; i++) begin
				pipe[i] <= '0;
			end
		end else if (!stall) begin
			pipe[1] <= step_cur;
			for (int i = 2; i <= DEPTH; i++) begin
				pipe[i] <= pipe[i-1];
			end
		end
	end

	// bank data lines up with stage 3
	always_ff @(posedge clk) begin
		if (!stall) begin
			sel_a <= q_a[pipe[DEPTH-1].read_num[`SMEM_READ_NUM_WIDTH-1 -: `SMEM_BANK_SEL_WIDTH]];
			sel_b <= q_b[pipe[DEPTH-1].read_num[`SMEM_READ_NUM_WIDTH-1 -: `SMEM_BANK_SEL_WIDTH]];
		end
	end

	// ------------------------------------------------------------
	// word format
	// ------------------------------------------------------------

	always_comb begin
		word = '0;
		case (pipe[DEPTH].state)
			smem_pkg::HEADER: begin
				word[9:0]     = 10'(pipe[DEPTH].read_num);
				word[70:64]   = pipe[DEPTH].size;
				word[135:128] = 8'(pipe[DEPTH].ret);
			end
			smem_pkg::PAIRS: begin
				word = {pack_half(sel_b), pack_half(sel_a)};
			end
			smem_pkg::TAIL: begin
				// odd count, high half stays zero
				word[HALF_W-1:0] = pack_half(sel_a);
			end
			default: begin
				word = '0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			output_valid  <= 1'b0;
			output_finish <= 1'b0;
		end else if (!stall) begin
			output_valid  <= pipe[DEPTH].valid;
			output_finish <= pipe[DEPTH].finish;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			output_data <= word;
		end
	end

	// a size rewritten mid-read would walk past the last mem
	slot_below_size: assert property (@(posedge clk) disable iff (!reset_n)
		(state == smem_pkg::PAIRS || state == smem_pkg::TAIL) |-> slot < rd_size);

endmodule

// File: smem_result_buffer.sv
`timescale 1ns/1ps
`include "smem_config.svh"

module smem_result_buffer (
	input  logic                          clk,
	input  logic                          reset_n,
	input  logic                          stall,
	input  logic [`SMEM_READ_NUM_WIDTH:0] batch_size,
	input  smem_pkg::mem_write_t          mem_wr,
	input  smem_pkg::size_report_t        size_rep,
	input  logic                          output_permit,
	output logic                          output_request,
	output logic [`SMEM_READ_NUM_WIDTH:0] done_counter,
	output logic [`SMEM_OUT_WIDTH-1:0]    output_data,
	output logic                          output_valid,
	output logic                          output_finish
);

	smem_pkg::bank_rd_t               rd;
	logic [`SMEM_BANKS-1:0]           bank_we;
	logic [`SMEM_BANK_ADDR_WIDTH-1:0] bank_addr_a;
	logic [`SMEM_BANK_ADDR_WIDTH-1:0] bank_addr_b;
	smem_pkg::mem_entry_t             bank_wdata;
	smem_pkg::mem_entry_t             q_a [`SMEM_BANKS];
	smem_pkg::mem_entry_t             q_b [`SMEM_BANKS];
	logic [`SMEM_READ_NUM_WIDTH-1:0]  rd_num;
	logic [`SMEM_SIZE_WIDTH-1:0]      rd_size;
	logic [`SMEM_SIZE_WIDTH-1:0]      rd_ret;

	smem_write_router smem_write_router_i (
		.clk     (clk),
		.reset_n (reset_n),
		.stall   (stall),
		.mem_wr  (mem_wr),
		.rd      (rd),
		.bank_we (bank_we),
		.addr_a  (bank_addr_a),
		.wdata   (bank_wdata),
		.addr_b  (bank_addr_b)
	);

	// ------------------------------------------------------------
	// mem banks
	// ------------------------------------------------------------

	generate
		for (genvar b = 0; b < `SMEM_BANKS; b++) begin : g_bank
			smem_bank smem_bank_i (
				.clk    (clk),
				.enable (!stall),
				.we     (bank_we[b]),
				.addr_a (bank_addr_a),
				.wdata  (bank_wdata),
				.addr_b (bank_addr_b),
				.q_a    (q_a[b]),
				.q_b    (q_b[b])
			);
		end
	endgenerate

	smem_batch_tracker smem_batch_tracker_i (
		.clk            (clk),
		.reset_n        (reset_n),
		.stall          (stall),
		.size_rep       (size_rep),
		.batch_size     (batch_size),
		.rd_num         (rd_num),
		.rd_size        (rd_size),
		.rd_ret         (rd_ret),
		.done_counter   (done_counter),
		.output_request (output_request)
	);

	smem_output_streamer smem_output_streamer_i (
		.clk           (clk),
		.reset_n       (reset_n),
		.stall         (stall),
		.output_permit (output_permit),
		.batch_size    (batch_size),
		.rd_size       (rd_size),
		.rd_ret        (rd_ret),
		.rd_num        (rd_num),
		.rd            (rd),
		.q_a           (q_a),
		.q_b           (q_b),
		.output_data   (output_data),
		.output_valid  (output_valid),
		.output_finish (output_finish)
	);

endmodule

// File: tb_smem_result_buffer.sv
`timescale 1ns/1ps
`include "smem_config.svh"

module tb_smem_result_buffer;

	localparam int HALF_W = `SMEM_OUT_WIDTH / 2;

	logic                           clk;
	logic                           reset_n;
	logic                           stall;
	logic [`SMEM_READ_NUM_WIDTH:0]  batch_size;
	smem_pkg::mem_write_t           mem_wr;
	smem_pkg::size_report_t         size_rep;
	logic                           output_permit;
	logic                           output_request;
	logic [`SMEM_READ_NUM_WIDTH:0]  done_counter;
	logic [`SMEM_OUT_WIDTH-1:0]     output_data;
	logic                           output_valid;
	logic                           output_finish;

	// records from the tests file
	smem_pkg::mem_write_t           wr_q [$];
	smem_pkg::size_report_t         rep_q [$];
	logic [`SMEM_OUT_WIDTH-1:0]     exp_q [$];
	bit                             exp_hdr_q [$];
	logic [`SMEM_READ_NUM_WIDTH:0]  file_batch;
	int                             rec_count;
	bit                             tests_loaded;

	integer seed;
	int     errors;
	int     checks;
	int     exp_idx;
	int     finish_cycles;
	int     wait_cycles;
	int     permit_delay;
	bit     saw_gap;
	bit     live;

	initial clk = 1'b0;
	always #20 clk = ~clk;

	smem_result_buffer smem_result_buffer_i (
		.clk            (clk),
		.reset_n        (reset_n),
		.stall          (stall),
		.batch_size     (batch_size),
		.mem_wr         (mem_wr),
		.size_rep       (size_rep),
		.output_permit  (output_permit),
		.output_request (output_request),
		.done_counter   (done_counter),
		.output_data    (output_data),
		.output_valid   (output_valid),
		.output_finish  (output_finish)
	);

	task automatic report_problem(input string msg);
		errors++;
		$display("error: %s", msg);
	endtask

	// ------------------------------------------------------------
	// tests file
	// ------------------------------------------------------------

	task automatic load_tests();
		int                              fd;
		int                              n;
		int                              count;
		string                           line;
		byte                             kind;
		logic [`SMEM_READ_NUM_WIDTH-1:0] rn;
		logic [`SMEM_SIZE_WIDTH-1:0]     slot;
		logic [`SMEM_SIZE_WIDTH-1:0]     ret;
		logic [6:0]                      ih;
		logic [6:0]                      il;
		logic [32:0]                     x2;
		logic [32:0]                     x1;
		logic [32:0]                     x0;
		logic [HALF_W-1:0]               half;
		logic [`SMEM_OUT_WIDTH-1:0]      word;
		smem_pkg::mem_write_t            wr;
		smem_pkg::size_report_t          rep;
		count = 0;
		fd = $fopen("smem_tests.txt", "r");
		if (fd == 0) begin
			report_problem("cannot open smem_tests.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 1 && line.getc(0) != "#") begin
					kind = line.getc(0);
					case (kind)
						"B": begin
							n = $sscanf(line, "B %h", file_batch);
						end
						"W": begin
							n = $sscanf(line, "W %h %h %h %h %h %h %h",
								rn, slot, ih, il, x2, x1, x0);
							wr = '0;
							wr.we = 1'b1;
							wr.read_num = rn;
							wr.slot = slot;
							wr.entry = '{info_hi: ih, info_lo: il, x2: x2, x1: x1, x0: x0};
							wr_q.push_back(wr);
						end
						"S": begin
							n = $sscanf(line, "S %h %h %h", rn, slot, ret);
							rep = '{valid: 1'b1, read_num: rn, size: slot, ret: ret};
							rep_q.push_back(rep);
						end
						"H", "E": begin
							n = $sscanf(line, "%c %h", kind, word);
							exp_q.push_back(word);
							exp_hdr_q.push_back(kind == "H");
						end
						"U": begin
							// upper half of the word before it
							n = $sscanf(line, "U %h", half);
							word = exp_q.pop_back();
							word[`SMEM_OUT_WIDTH-1:HALF_W] = half;
							exp_q.push_back(word);
						end
						default: begin
							report_problem("unknown record kind in smem_tests.txt");
						end
					endcase
					count++;
				end
			end
			$fclose(fd);
		end
		rec_count = count;
		tests_loaded = 1'b1;
	endtask

	// ------------------------------------------------------------
	// cycle helpers
	// ------------------------------------------------------------

	// live tells whether the edge just passed was unstalled
	task automatic next_cycle();
		live = !stall;
		@(posedge clk);
		#2;
		stall = (($random(seed) & 3) == 0);
	endtask

	task automatic live_cycle();
		next_cycle();
		while (!live) begin
			next_cycle();
		end
	endtask

	// one sample per unstalled edge
	task automatic check_outputs();
		if (output_valid) begin
			checks++;
			assert (exp_idx < exp_q.size())
			else report_problem("output_valid high after the last expected word");
			if (exp_idx < exp_q.size()) begin
				if (exp_hdr_q[exp_idx] && exp_idx > 0) begin
					checks++;
					assert (saw_gap)
					else report_problem("no idle cycle before a read header");
				end
				checks++;
				assert (output_data === exp_q[exp_idx]) else begin
					errors++;
					$display("[FAIL] output_data word %0d: got %h, expected %h",
						exp_idx, output_data, exp_q[exp_idx]);
				end
				exp_idx++;
			end
			saw_gap = 1'b0;
		end else begin
			saw_gap = 1'b1;
		end
		checks++;
		assert (output_finish || finish_cycles == 0)
		else report_problem("output_finish fell after rising");
		if (output_finish) begin
			checks++;
			assert (exp_idx == exp_q.size() && !output_valid)
			else report_problem("output_finish high with words missing or output_valid high");
			finish_cycles++;
		end
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------

	initial begin
		reset_n = 1'b0;
		stall = 1'b0;
		batch_size = '0;
		mem_wr = '0;
		size_rep = '0;
		output_permit = 1'b0;
		seed = 32'hda1b880e;
		errors = 0;
		checks = 0;
		exp_idx = 0;
		finish_cycles = 0;
		saw_gap = 1'b0;
		load_tests();
		batch_size = file_batch;
		repeat (5) @(posedge clk);
		#2;
		reset_n = 1'b1;
		checks++;
		assert (!output_request && !output_valid && !output_finish && done_counter == '0)
		else report_problem("outputs not idle after reset");

		foreach (wr_q[i]) begin
			mem_wr = wr_q[i];
			live_cycle();
		end
		mem_wr = '0;

		// each report gets two live edges before the count is checked
		foreach (rep_q[i]) begin
			size_rep = rep_q[i];
			live_cycle();
			size_rep = '0;
			live_cycle();
			checks++;
			assert (done_counter == i + 1) else begin
				errors++;
				$display("[FAIL] done_counter: got %h, expected %h", done_counter, i + 1);
			end
			checks++;
			assert (!output_request)
			else report_problem("output_request rose before the last size report");
		end

		wait_cycles = 0;
		while (!output_request && wait_cycles < 40) begin
			next_cycle();
			wait_cycles++;
		end
		checks++;
		assert (output_request)
		else report_problem("output_request did not rise after the last size report");
		permit_delay = ($random(seed) & 7) + 1;
		repeat (permit_delay) begin
			next_cycle();
			checks++;
			assert (output_request) else report_problem("output_request fell before permit");
		end
		output_permit = 1'b1;

		while (finish_cycles < 4) begin
			next_cycle();
			output_permit = (($random(seed) & 3) != 0);
			if (live) begin
				check_outputs();
			end
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// run length scales with the record count
	initial begin
		wait (tests_loaded);
		#(40.0 * 20 * rec_count);
		$display("error: timeout, the stream did not finish in time");
		$display("checks %0d, errors %0d", checks, errors);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: smem_tests.txt
# B batch | W read slot info_hi info_lo x2 x1 x0 | S read size ret   (all hex)
# H header word, E data word low half, U high half of the word before it
B 0d
# ------------------------------------------------------------
W 1 0 01 02 100000013 000000012 000000011
W 1 1 03 04 000000023 100000022 000000021
W 1 2 05 06 000000033 000000032 100000031
W 5 0 07 08 000000053 000000052 000000051
W 5 1 09 0a 000000063 000000062 000000061
W a 0 0b 0c 1000000a3 0000000a2 0000000a1
W c 0 0d 0e 0000000c3 0000000c2 0000000c1
W c 1 0f 10 0000000d3 0000000d2 0000000d1
W c 2 11 12 0000000e3 0000000e2 0000000e1
W c 3 13 14 1000000f3 0000000f2 1000000f1
# ------------------------------------------------------------
S 0 0 30
S 1 3 31
S 2 0 32
S 3 0 33
S 4 0 34
S 5 2 35
S 6 0 36
S 7 0 37
S 8 0 38
S 9 0 39
S a 1 3a
S b 0 3b
S c 4 3c
# ------------------------------------------------------------
H 3000000000000000000000000000000000
H 3100000000000000030000000000000001
E 0000000100000002000000010000001300000000000000120000000000000011
U 0000000300000004000000000000002300000001000000220000000000000021
E 0000000500000006000000000000003300000000000000320000000100000031
H 3200000000000000000000000000000002
H 3300000000000000000000000000000003
H 3400000000000000000000000000000004
H 3500000000000000020000000000000005
E 0000000700000008000000000000005300000000000000520000000000000051
U 000000090000000a000000000000006300000000000000620000000000000061
H 3600000000000000000000000000000006
H 3700000000000000000000000000000007
H 3800000000000000000000000000000008
H 3900000000000000000000000000000009
H 3a0000000000000001000000000000000a
E 0000000b0000000c00000001000000a300000000000000a200000000000000a1
H 3b0000000000000000000000000000000b
H 3c0000000000000004000000000000000c
E 0000000d0000000e00000000000000c300000000000000c200000000000000c1
U 0000000f0000001000000000000000d300000000000000d200000000000000d1
E 000000110000001200000000000000e300000000000000e200000000000000e1
U 000000130000001400000001000000f300000000000000f200000001000000f1

// File: sources.f
+incdir+.
smem_pkg.sv
smem_bank.sv
smem_write_router.sv
smem_batch_tracker.sv
smem_output_streamer.sv
smem_result_buffer.sv
tb_smem_result_buffer.sv

// File: Bender.yml
package:
  name: smem_result_buffer

export_include_dirs:
  - .

sources:
  - smem_pkg.sv
  - smem_bank.sv
  - smem_write_router.sv
  - smem_batch_tracker.sv
  - smem_output_streamer.sv
  - smem_result_buffer.sv
  - target: test
    files:
      - tb_smem_result_buffer.sv
